// File: hdl/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // index 0 of the physical register file is the hardwired zero
    localparam int NUM_PREGS = 64;
    localparam int PREG_W    = 6;

    // lanes per cycle
    localparam int RENAME_WIDTH = 2;
    localparam int COMMIT_WIDTH = 2;

    // reference counts per register
    localparam int CNT_W = 6;

    // free list holds every register except 0
    localparam int FL_DEPTH = NUM_PREGS - 1;
    localparam int FL_CNT_W = 6;

endpackage

`default_nettype wire

// File: hdl/free_list.sv
`timescale 1ns/1ns
`default_nettype none

module free_list import rename_pkg::*; (
    input  wire                            clk,
    input  wire                            i_reset,
    input  wire  [1:0]                     i_pop_cnt,
    input  wire  [COMMIT_WIDTH-1:0]        i_push_en,
    input  wire  [COMMIT_WIDTH*PREG_W-1:0] i_push_preg,
    output logic [RENAME_WIDTH*PREG_W-1:0] o_head_preg,
    output logic [FL_CNT_W-1:0]            o_count
);

    logic [PREG_W-1:0]   mem [0:FL_DEPTH-1];
    logic [FL_CNT_W-1:0] head;
    logic [FL_CNT_W-1:0] tail;
    logic [FL_CNT_W-1:0] count;
    logic [FL_CNT_W-1:0] wr_ptr [COMMIT_WIDTH];
    logic [1:0]          push_cnt;
    logic [FL_CNT_W:0]   count_next;

    // pointer advance with wrap at the buffer depth
    function automatic logic [FL_CNT_W-1:0] ptr_add(
        input logic [FL_CNT_W-1:0] ptr,
        input logic [1:0]          n
    );
        logic [FL_CNT_W:0] sum;
        sum = {1'b0, ptr} + {{(FL_CNT_W-1){1'b0}}, n};
        if (sum >= (FL_CNT_W+1)'(FL_DEPTH)) begin
            sum = sum - (FL_CNT_W+1)'(FL_DEPTH);
        end
        return sum[FL_CNT_W-1:0];
    endfunction

    // pushes append in lane order, a disabled lane takes no slot
    always_comb begin
        push_cnt = '0;
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            wr_ptr[l] = ptr_add(tail, push_cnt);
            push_cnt  = push_cnt + 2'(i_push_en[l]);
        end
    end

    // head entries seen by the rename lanes
    always_comb begin
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            o_head_preg[l*PREG_W +: PREG_W] = mem[ptr_add(head, 2'(l))];
        end
    end

    assign count_next = {1'b0, count} + {{(FL_CNT_W-1){1'b0}}, push_cnt}
                      - {{(FL_CNT_W-1){1'b0}}, i_pop_cnt};

    // full at reset, so tail sits on head
    always_ff @(posedge clk) begin
        if (i_reset) begin
            head  <= '0;
            tail  <= '0;
            count <= FL_CNT_W'(FL_DEPTH);
            for (int i = 0; i < FL_DEPTH; i++) begin
                mem[i] <= PREG_W'(i + 1);
            end
        end else begin
            head  <= ptr_add(head, i_pop_cnt);
            tail  <= ptr_add(tail, push_cnt);
            count <= count_next[FL_CNT_W-1:0];
            for (int l = 0; l < COMMIT_WIDTH; l++) begin
                if (i_push_en[l]) begin
                    mem[wr_ptr[l]] <= i_push_preg[l*PREG_W +: PREG_W];
                end
            end
        end
    end

    assign o_count = count;

    // allocator only pops entries present at the start of the cycle
    a_no_underrun: assert property (
        @(posedge clk) disable iff (i_reset)
        {{(FL_CNT_W-2){1'b0}}, i_pop_cnt} <= count
    );

    // reclaim never finds the buffer full, the pool is only 63 entries
    a_no_overrun: assert property (
        @(posedge clk) disable iff (i_reset)
        ({1'b0, count} + {{(FL_CNT_W-1){1'b0}}, push_cnt})
            <= (FL_CNT_W+1)'(FL_DEPTH)
    );

endmodule

`default_nettype wire

// File: hdl/ref_counter.sv
`timescale 1ns/1ns
`default_nettype none

module ref_counter import rename_pkg::*; (
    input  wire                            clk,
    input  wire                            i_reset,
    input  wire  [RENAME_WIDTH-1:0]        i_inc_en,
    input  wire  [RENAME_WIDTH*PREG_W-1:0] i_inc_preg,
    input  wire  [COMMIT_WIDTH-1:0]        i_dec_en,
    input  wire  [COMMIT_WIDTH*PREG_W-1:0] i_dec_preg,
    output logic [COMMIT_WIDTH-1:0]        o_release
);

    // register 0 has no counter
    logic [CNT_W-1:0]     cnt      [1:NUM_PREGS-1];
    logic [CNT_W-1:0]     cnt_next [0:NUM_PREGS-1];
    logic [NUM_PREGS-1:1] underflow;
    logic [NUM_PREGS-1:1] overflow;

    // lanes hitting one register all count, not just once
    always_comb begin : count_update
        logic [1:0]     n_inc;
        logic [1:0]     n_dec;
        logic [CNT_W:0] raised;
        logic [CNT_W:0] net;
        cnt_next[0] = '0;
        for (int r = 1; r < NUM_PREGS; r++) begin
            n_inc = '0;
            n_dec = '0;
            for (int l = 0; l < RENAME_WIDTH; l++) begin
                if (i_inc_en[l] && i_inc_preg[l*PREG_W +: PREG_W] == PREG_W'(r)) begin
                    n_inc = n_inc + 2'd1;
                end
            end
            for (int l = 0; l < COMMIT_WIDTH; l++) begin
                if (i_dec_en[l] && i_dec_preg[l*PREG_W +: PREG_W] == PREG_W'(r)) begin
                    n_dec = n_dec + 2'd1;
                end
            end
            raised       = {1'b0, cnt[r]} + (CNT_W+1)'(n_inc);
            net          = raised - (CNT_W+1)'(n_dec);
            underflow[r] = raised < (CNT_W+1)'(n_dec);
            overflow[r]  = net[CNT_W] & ~underflow[r];
            cnt_next[r]  = net[CNT_W-1:0];
        end
    end

    // last release of a register is reported once
    always_comb begin : release_detect
        logic [PREG_W-1:0] preg;
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            preg         = i_dec_preg[l*PREG_W +: PREG_W];
            o_release[l] = i_dec_en[l] && (preg != '0) && (cnt_next[preg] == '0);
            // a higher lane on the same register takes the flag
            for (int m = l + 1; m < COMMIT_WIDTH; m++) begin
                if (i_dec_en[m] && i_dec_preg[m*PREG_W +: PREG_W] == preg) begin
                    o_release[l] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 1; r < NUM_PREGS; r++) begin
            if (i_reset) begin
                cnt[r] <= '0;
            end else begin
                cnt[r] <= cnt_next[r];
            end
        end
    end

    // commit only releases live references
    a_no_underflow: assert property (
        @(posedge clk) disable iff (i_reset)
        underflow == '0
    );

    // rename plus moves never stack more than CNT_W can hold
    a_no_overflow: assert property (
        @(posedge clk) disable iff (i_reset)
        overflow == '0
    );

endmodule

`default_nettype wire

// File: hdl/rename_alloc.sv
`timescale 1ns/1ns
`default_nettype none

module rename_alloc import rename_pkg::*; (
    input  wire                            clk,
    input  wire                            i_reset,
    input  wire                            i_ren_valid,
    input  wire  [RENAME_WIDTH-1:0]        i_ren_lane_en,
    input  wire  [RENAME_WIDTH-1:0]        i_ren_is_move,
    input  wire  [RENAME_WIDTH*PREG_W-1:0] i_ren_src_preg,
    output logic                           o_ren_ready,
    output logic [RENAME_WIDTH*PREG_W-1:0] o_ren_preg,
    input  wire  [COMMIT_WIDTH-1:0]        i_com_valid,
    input  wire  [COMMIT_WIDTH*PREG_W-1:0] i_com_preg,
    input  wire  [RENAME_WIDTH*PREG_W-1:0] i_fl_head,
    input  wire  [FL_CNT_W-1:0]            i_fl_count,
    input  wire  [COMMIT_WIDTH-1:0]        i_release,
    output logic [1:0]                     o_pop_cnt,
    output logic [COMMIT_WIDTH-1:0]        o_push_en,
    output logic [COMMIT_WIDTH*PREG_W-1:0] o_push_preg,
    output logic [RENAME_WIDTH-1:0]        o_inc_en,
    output logic [RENAME_WIDTH*PREG_W-1:0] o_inc_preg
);

    logic [RENAME_WIDTH-1:0] fresh;
    logic [1:0]              fresh_cnt;
    logic                    accept;

    assign fresh = i_ren_lane_en & ~i_ren_is_move;

    // fresh lanes take heads in lane order, moves keep their source
    always_comb begin : lane_map
        logic [1:0] slot;
        slot = '0;
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (fresh[l]) begin
                o_ren_preg[l*PREG_W +: PREG_W] = i_fl_head[slot*PREG_W +: PREG_W];
                slot = slot + 2'd1;
            end else if (i_ren_lane_en[l]) begin
                o_ren_preg[l*PREG_W +: PREG_W] = i_ren_src_preg[l*PREG_W +: PREG_W];
            end else begin
                o_ren_preg[l*PREG_W +: PREG_W] = '0;
            end
        end
        fresh_cnt = slot;
    end

    // whole group or nothing
    assign o_ren_ready = i_fl_count >= {{(FL_CNT_W-2){1'b0}}, fresh_cnt};
    assign accept      = i_ren_valid & o_ren_ready;
    assign o_pop_cnt   = accept ? fresh_cnt : 2'd0;

    // one reference per accepted lane except the zero register
    always_comb begin
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            o_inc_preg[l*PREG_W +: PREG_W] = o_ren_preg[l*PREG_W +: PREG_W];
            o_inc_en[l] = accept && i_ren_lane_en[l]
                       && (o_ren_preg[l*PREG_W +: PREG_W] != '0);
        end
    end

    // release flags wait one cycle while the counts settle
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_push_en <= '0;
        end else begin
            o_push_en <= i_release & i_com_valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            if (i_com_valid[l]) begin
                o_push_preg[l*PREG_W +: PREG_W] <= i_com_preg[l*PREG_W +: PREG_W];
            end
        end
    end

    // the zero register must never come back to the free list
    for (genvar l = 0; l < COMMIT_WIDTH; l++) begin : g_push_chk
        a_push_nonzero: assert property (
            @(posedge clk) disable iff (i_reset)
            o_push_en[l] |-> (o_push_preg[l*PREG_W +: PREG_W] != '0)
        );
    end

endmodule

`default_nettype wire

// File: hdl/phys_reg_mgr.sv
`timescale 1ns/1ns
`default_nettype none

module phys_reg_mgr import rename_pkg::*; (
    input  wire                            clk,
    input  wire                            i_reset,
    // rename group
    input  wire                            i_ren_valid,
    input  wire  [RENAME_WIDTH-1:0]        i_ren_lane_en,
    input  wire  [RENAME_WIDTH-1:0]        i_ren_is_move,
    input  wire  [RENAME_WIDTH*PREG_W-1:0] i_ren_src_preg,
    output logic                           o_ren_ready,
    output logic [RENAME_WIDTH*PREG_W-1:0] o_ren_preg,
    // commit release lanes carry no ready
    input  wire  [COMMIT_WIDTH-1:0]        i_com_valid,
    input  wire  [COMMIT_WIDTH*PREG_W-1:0] i_com_preg,
    output logic [FL_CNT_W-1:0]            o_free_count
);

    logic [1:0]                     pop_cnt;
    logic [COMMIT_WIDTH-1:0]        push_en;
    logic [COMMIT_WIDTH*PREG_W-1:0] push_preg;
    logic [RENAME_WIDTH*PREG_W-1:0] fl_head;
    logic [FL_CNT_W-1:0]            fl_count;
    logic [RENAME_WIDTH-1:0]        inc_en;
    logic [RENAME_WIDTH*PREG_W-1:0] inc_preg;
    logic [COMMIT_WIDTH-1:0]        release_flag;

    free_list u_free_list (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_pop_cnt   (pop_cnt),
        .i_push_en   (push_en),
        .i_push_preg (push_preg),
        .o_head_preg (fl_head),
        .o_count     (fl_count)
    );

    // commit lanes decrement directly
    ref_counter u_ref_counter (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_inc_en   (inc_en),
        .i_inc_preg (inc_preg),
        .i_dec_en   (i_com_valid),
        .i_dec_preg (i_com_preg),
        .o_release  (release_flag)
    );

    rename_alloc u_rename_alloc (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_ren_valid    (i_ren_valid),
        .i_ren_lane_en  (i_ren_lane_en),
        .i_ren_is_move  (i_ren_is_move),
        .i_ren_src_preg (i_ren_src_preg),
        .o_ren_ready    (o_ren_ready),
        .o_ren_preg     (o_ren_preg),
        .i_com_valid    (i_com_valid),
        .i_com_preg     (i_com_preg),
        .i_fl_head      (fl_head),
        .i_fl_count     (fl_count),
        .i_release      (release_flag),
        .o_pop_cnt      (pop_cnt),
        .o_push_en      (push_en),
        .o_push_preg    (push_preg),
        .o_inc_en       (inc_en),
        .o_inc_preg     (inc_preg)
    );

    assign o_free_count = fl_count;

endmodule

`default_nettype wire

// File: tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// expected DUT state advances once per rising edge
int free_q [$];
int ref_cnt [NUM_PREGS];
int held_q [$];
int pend_q [$];
int err_count;
int check_count;

// expected ready and lane assignments for a group against the current state
function automatic void expect_group(
    input  logic [RENAME_WIDTH-1:0]        en,
    input  logic [RENAME_WIDTH-1:0]        mv,
    input  logic [RENAME_WIDTH*PREG_W-1:0] src,
    output logic                           ready,
    output int                             p0,
    output int                             p1
);
    int slot;
    int p [RENAME_WIDTH];
    slot = 0;
    for (int l = 0; l < RENAME_WIDTH; l++) begin
        p[l] = 0;
        if (en[l] && !mv[l]) begin
            if (slot < free_q.size()) begin
                p[l] = free_q[slot];
            end
            slot++;
        end else if (en[l]) begin
            p[l] = src[l*PREG_W +: PREG_W];
        end
    end
    ready = free_q.size() >= slot;
    p0 = p[0];
    p1 = p[1];
endfunction

task automatic check_value(input string name, input int expected, input int actual);
    check_count++;
    if (expected != actual) begin
        err_count++;
        $display("ERROR at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
    end
endtask

task automatic model_reset();
    free_q.delete();
    held_q.delete();
    pend_q.delete();
    for (int r = 0; r < NUM_PREGS; r++) begin
        ref_cnt[r] = 0;
        if (r != 0) begin
            free_q.push_back(r);
        end
    end
endtask

task automatic model_step();
    logic ready;
    int   pr [RENAME_WIDTH];
    int   cp;
    logic seen;
    expect_group(ren_lane_en, ren_is_move, ren_src_preg, ready, pr[0], pr[1]);
    if (ren_valid && ready) begin
        for (int l = 0; l < RENAME_WIDTH; l++) begin
            if (ren_lane_en[l] && !ren_is_move[l]) begin
                cp = free_q.pop_front();
            end
            if (ren_lane_en[l] && pr[l] != 0) begin
                ref_cnt[pr[l]]++;
                held_q.push_back(pr[l]);
            end
        end
    end
    // releases from the previous cycle land behind the remaining entries
    foreach (pend_q[i]) begin
        free_q.push_back(pend_q[i]);
    end
    pend_q.delete();
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
        if (com_valid[l]) begin
            ref_cnt[com_preg[l*PREG_W +: PREG_W]]--;
        end
    end
    for (int l = 0; l < COMMIT_WIDTH; l++) begin
        cp = com_preg[l*PREG_W +: PREG_W];
        seen = 1'b0;
        foreach (pend_q[i]) begin
            if (pend_q[i] == cp) begin
                seen = 1'b1;
            end
        end
        if (com_valid[l] && cp != 0 && ref_cnt[cp] == 0 && !seen) begin
            pend_q.push_back(cp);
        end
    end
endtask

`endif

// File: tb/tb_phys_reg_mgr.sv
`timescale 1ns/1ns
`default_nettype none

module tb_phys_reg_mgr import rename_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int DRIVE_DELAY     = 10;
    localparam int RESET_CYCLES    = 2;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int WATCHDOG_CYCLES = 3000;

    logic                           clk;
    logic                           i_reset;
    logic                           ren_valid;
    logic [RENAME_WIDTH-1:0]        ren_lane_en;
    logic [RENAME_WIDTH-1:0]        ren_is_move;
    logic [RENAME_WIDTH*PREG_W-1:0] ren_src_preg;
    logic                           ren_ready;
    logic [RENAME_WIDTH*PREG_W-1:0] ren_preg;
    logic [COMMIT_WIDTH-1:0]        com_valid;
    logic [COMMIT_WIDTH*PREG_W-1:0] com_preg;
    logic [FL_CNT_W-1:0]            free_count;
    logic [31:0]                    lcg_state;

    `include "tb_ref_model.svh"

    phys_reg_mgr uut (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_ren_valid    (ren_valid),
        .i_ren_lane_en  (ren_lane_en),
        .i_ren_is_move  (ren_is_move),
        .i_ren_src_preg (ren_src_preg),
        .o_ren_ready    (ren_ready),
        .o_ren_preg     (ren_preg),
        .i_com_valid    (com_valid),
        .i_com_preg     (com_preg),
        .o_free_count   (free_count)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic int lcg_below(input int n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]) % n;
    endfunction

    // model follows the same edge the DUT samples on
    always @(posedge clk) begin
        if (i_reset) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : compare
        logic exp_ready;
        int   p0;
        int   p1;
        if (!i_reset) begin
            expect_group(ren_lane_en, ren_is_move, ren_src_preg, exp_ready, p0, p1);
            check_value("o_free_count", free_q.size(), free_count);
            check_value("o_ren_ready", exp_ready, ren_ready);
            if (ren_valid && exp_ready && ren_lane_en[0]) begin
                check_value("o_ren_preg[0]", p0, ren_preg[PREG_W-1:0]);
            end
            if (ren_valid && exp_ready && ren_lane_en[1]) begin
                check_value("o_ren_preg[1]", p1, ren_preg[2*PREG_W-1:PREG_W]);
            end
        end
    end

    task automatic advance_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
        com_valid = '0;
    endtask

    task automatic drive_group(input logic v, input logic [1:0] en, input logic [1:0] mv,
                               input int src0, input int src1);
        ren_valid    = v;
        ren_lane_en  = en;
        ren_is_move  = mv;
        ren_src_preg = {PREG_W'(src1), PREG_W'(src0)};
    endtask

    task automatic drive_commit(input logic [1:0] v, input int p0, input int p1);
        com_valid = v;
        com_preg  = {PREG_W'(p1), PREG_W'(p0)};
    endtask

    task automatic drop_reference(input int p);
        int idx;
        idx = -1;
        foreach (held_q[i]) begin
            if (held_q[i] == p && idx < 0) begin
                idx = i;
            end
        end
        if (idx >= 0) begin
            held_q.delete(idx);
        end
    endtask

    task automatic commit_random(input int n);
        int idx;
        int pick [COMMIT_WIDTH];
        logic [COMMIT_WIDTH-1:0] v;
        v = '0;
        for (int l = 0; l < COMMIT_WIDTH; l++) begin
            pick[l] = 0;
            if (l < n && held_q.size() > 0) begin
                idx = lcg_below(held_q.size());
                pick[l] = held_q[idx];
                held_q.delete(idx);
                v[l] = 1'b1;
            end
        end
        drive_commit(v, pick[0], pick[1]);
    endtask

    task automatic random_cycle();
        int live [$];
        logic [1:0] en;
        logic [1:0] mv;
        int src [2];
        int ncom;
        // counts kept well below the counter limit
        for (int r = 1; r < NUM_PREGS; r++) begin
            if (ref_cnt[r] > 0 && ref_cnt[r] < 60) begin
                live.push_back(r);
            end
        end
        en = 2'(lcg_below(4));
        for (int l = 0; l < 2; l++) begin
            mv[l] = lcg_below(10) < 3;
            src[l] = 0;
            if (mv[l] && live.size() > 0 && lcg_below(8) != 0) begin
                src[l] = live[lcg_below(live.size())];
            end
        end
        drive_group(lcg_below(8) != 0, en, mv, src[0], src[1]);
        ncom = (held_q.size() < 20) ? lcg_below(2) : lcg_below(3);
        if (free_q.size() < 6) begin
            ncom = 2;
        end
        commit_random(ncom);
    endtask

    initial begin : stimulus
        int   p;
        int   base;
        int   waited;
        logic accepted;
        lcg_state   = 32'd39789;
        err_count   = 0;
        check_count = 0;
        i_reset     = 1'b1;
        drive_group(1'b0, 2'b00, 2'b00, 0, 0);
        drive_commit(2'b00, 0, 0);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        i_reset = 1'b0;

        // fresh lanes come off the list in order
        check_value("o_free_count", 63, free_count);
        drive_group(1'b1, 2'b11, 2'b00, 0, 0);
        @(negedge clk);
        check_value("o_ren_preg[0]", 1, ren_preg[PREG_W-1:0]);
        check_value("o_ren_preg[1]", 2, ren_preg[2*PREG_W-1:PREG_W]);
        advance_cycle();
        drive_group(1'b1, 2'b10, 2'b00, 0, 0);
        @(negedge clk);
        check_value("o_ren_preg[1]", 3, ren_preg[2*PREG_W-1:PREG_W]);
        advance_cycle();

        // move lanes pass the source, a move from 0 changes nothing
        drive_group(1'b1, 2'b11, 2'b01, 1, 0);
        @(negedge clk);
        check_value("o_ren_preg[0]", 1, ren_preg[PREG_W-1:0]);
        check_value("o_ren_preg[1]", 4, ren_preg[2*PREG_W-1:PREG_W]);
        advance_cycle();
        drive_group(1'b1, 2'b01, 2'b01, 0, 0);
        base = free_count;
        advance_cycle();
        check_value("o_free_count", base, free_count);

        // one rename plus two moves needs three releases
        p = free_q[0];
        drive_group(1'b1, 2'b01, 2'b00, 0, 0);
        advance_cycle();
        drive_group(1'b1, 2'b11, 2'b11, p, p);
        advance_cycle();
        drive_group(1'b0, 2'b00, 2'b00, 0, 0);
        for (int k = 0; k < 3; k++) begin
            drop_reference(p);
            drive_commit(2'b01, p, 0);
            advance_cycle();
        end
        base = free_count;
        advance_cycle();
        check_value("o_free_count", base + 1, free_count);

        // both commit lanes drop the last two references together
        p = free_q[0];
        drive_group(1'b1, 2'b01, 2'b00, 0, 0);
        advance_cycle();
        drive_group(1'b1, 2'b01, 2'b01, p, 0);
        advance_cycle();
        drive_group(1'b0, 2'b00, 2'b00, 0, 0);
        drop_reference(p);
        drop_reference(p);
        drive_commit(2'b11, p, p);
        advance_cycle();
        base = free_count;
        advance_cycle();
        check_value("o_free_count", base + 1, free_count);

        // drain the list, then stall until commits refill it
        while (free_q.size() >= 2) begin
            drive_group(1'b1, 2'b11, 2'b00, 0, 0);
            advance_cycle();
        end
        drive_group(1'b1, 2'b11, 2'b00, 0, 0);
        base = free_count;
        repeat (3) begin
            @(negedge clk);
            check_value("o_ren_ready", 0, ren_ready);
            check_value("o_free_count", base, free_count);
            advance_cycle();
        end
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && waited < 40) begin
            commit_random(2);
            @(negedge clk);
            accepted = ren_ready;
            advance_cycle();
            waited++;
        end
        if (!accepted) begin
            err_count++;
            $display("stalled rename group was never accepted after commits refilled the list");
        end
        drive_group(1'b0, 2'b00, 2'b00, 0, 0);

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            random_cycle();
            advance_cycle();
        end
        drive_group(1'b0, 2'b00, 2'b00, 0, 0);
        repeat (3) advance_cycle();

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+tb
hdl/rename_pkg.sv
hdl/free_list.sv
hdl/ref_counter.sv
hdl/rename_alloc.sv
hdl/phys_reg_mgr.sv
tb/tb_phys_reg_mgr.sv
